// ==== rtl/aluCore_config.svh ====
`ifndef ALU_CORE_CONFIG_SVH
`define ALU_CORE_CONFIG_SVH

// data path and instruction width
`define WORD_SIZE 16

// opcode field at the top of the instruction
`define OPCODE_WIDTH 4

// architectural registers
`define REG_NUM 8

// reorder buffer depth, which is also the number of tags
`define RB_SIZE 8

// number of ALU reservation stations
`define FU_NUM 3

// extra cycles a multiply spends after its operands are ready
`define MUL_STALL 3

`endif

// ==== rtl/isaPkg.sv ====
`include "aluCore_config.svh"

package isaPkg;

	localparam int REG_IDX_WIDTH = $clog2(`REG_NUM);
	// whatever is left below opcode, rd and rs
	localparam int IMM_WIDTH = `WORD_SIZE - `OPCODE_WIDTH - 2 * REG_IDX_WIDTH;

	typedef logic [REG_IDX_WIDTH-1:0] regIdxT;
	typedef logic [`WORD_SIZE-1:0] wordT;

	// anything not listed here is illegal and dropped at issue
	typedef enum logic [`OPCODE_WIDTH-1:0] {
		ADD  = 4'd0,
		SUB  = 4'd1,
		MUL  = 4'd2,
		ADDI = 4'd3,
		SUBI = 4'd4,
		MULI = 4'd5
	} opcodeT;

	// rt sits in the upper bits of the immediate field
	typedef struct packed {
		regIdxT rt;
		logic [IMM_WIDTH-REG_IDX_WIDTH-1:0] spare;
	} regFieldsT;

	typedef union packed {
		regFieldsT regs;
		logic [IMM_WIDTH-1:0] imm;
	} srcFieldT;

	typedef struct packed {
		opcodeT opcode;
		regIdxT rd;
		regIdxT rs;
		srcFieldT src;
	} instT;

endpackage

// ==== rtl/robPkg.sv ====
`include "aluCore_config.svh"

package robPkg;

	// one tag per reorder buffer entry
	typedef logic [$clog2(`RB_SIZE)-1:0] robTagT;

	// pending clear means the value is already held
	// with pending set the value comes from entry tag
	typedef struct packed {
		logic pending;
		robTagT tag;
	} operandTagT;

	// station number as carried by the dispatch lines
	typedef logic [$clog2(`FU_NUM)-1:0] stationIdT;

	// ready operand with no producer
	localparam operandTagT TAG_READY = '{pending: 1'b0, tag: '0};

endpackage

// ==== rtl/issueUnit.sv ====
`timescale 1ns/1ps
`include "aluCore_config.svh"

module issueUnit
	import isaPkg::*;
	import robPkg::*;
(
	input  logic instValid,
	input  instT inst,
	input  logic [`FU_NUM-1:0] stationBusy,
	input  logic robFull,
	output logic stall,
	output logic dispatch,
	output stationIdT dispatchStation,
	output opcodeT dispatchOp,
	output regIdxT rsIdx,
	output regIdxT rtIdx,
	output wordT imm,
	output logic allocate,
	output regIdxT allocReg
);

	logic legal;
	logic immForm;
	logic freeFound;
	stationIdT freeStation;

	// opcode classes: register form, immediate form, illegal
	always_comb begin
		legal = 1'b1;
		immForm = 1'b0;
		case (inst.opcode)
			ADD, SUB, MUL: immForm = 1'b0;
			ADDI, SUBI, MULI: immForm = 1'b1;
			default: legal = 1'b0;
		endcase
	end

	// scan downwards so the lowest free station wins
	always_comb begin
		freeFound = 1'b0;
		freeStation = '0;
		for (int i = `FU_NUM - 1; i >= 0; i--) begin
			if (!stationBusy[i]) begin
				freeFound = 1'b1;
				freeStation = stationIdT'(i);
			end
		end
	end

	// stall does not look at the opcode, an illegal one just waits its turn
	assign stall = !freeFound || robFull;

	// illegal opcodes are taken off the input but never dispatched
	assign dispatch = instValid && !stall && legal;
	assign allocate = dispatch;
	assign allocReg = inst.rd;

	assign dispatchStation = freeStation;
	assign dispatchOp = inst.opcode;
	assign rsIdx = inst.rs;
	// rt only means something for the register form
	assign rtIdx = immForm ? '0 : inst.src.regs.rt;
	// zero extended immediate
	assign imm = immForm ? wordT'(inst.src.imm) : '0;

endmodule

// ==== rtl/registerFile.sv ====
`timescale 1ns/1ps
`include "aluCore_config.svh"

module registerFile
	import isaPkg::*;
	import robPkg::*;
(
	input  logic clk,
	input  logic reset,
	input  regIdxT rsIdx,
	input  regIdxT rtIdx,
	input  logic allocate,
	input  regIdxT allocReg,
	input  robTagT tailTag,
	input  logic commitValid,
	input  regIdxT commitReg,
	input  robTagT commitTag,
	input  wordT commitValue,
	output wordT rsValue,
	output operandTagT rsTag,
	output wordT rtValue,
	output operandTagT rtTag
);

	wordT values [`REG_NUM];
	operandTagT tags [`REG_NUM];

	// true when the producer of this register retires in this very cycle
	function automatic logic commitHit(regIdxT idx);
		return tags[idx].pending && commitValid && tags[idx].tag == commitTag;
	endfunction

	// read ports, with the retiring value forwarded as ready
	assign rsValue = commitHit(rsIdx) ? commitValue : values[rsIdx];
	assign rsTag = commitHit(rsIdx) ? TAG_READY : tags[rsIdx];
	assign rtValue = commitHit(rtIdx) ? commitValue : values[rtIdx];
	assign rtTag = commitHit(rtIdx) ? TAG_READY : tags[rtIdx];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			// register i starts out holding i
			for (int i = 0; i < `REG_NUM; i++) begin
				values[i] <= wordT'(i);
				tags[i] <= TAG_READY;
			end
		end else begin
			if (commitValid) begin
				values[commitReg] <= commitValue;
				// a newer rename of the same register stays pending
				if (tags[commitReg].tag == commitTag) begin
					tags[commitReg].pending <= 1'b0;
				end
			end
			// allocation comes last so a fresh rename beats a same cycle commit
			if (allocate) begin
				tags[allocReg] <= '{pending: 1'b1, tag: tailTag};
			end
		end
	end

endmodule

// ==== rtl/aluStation.sv ====
`timescale 1ns/1ps
`include "aluCore_config.svh"

module aluStation
	import isaPkg::*;
	import robPkg::*;
#(
	parameter int stationIndex = 0
) (
	input  logic clk,
	input  logic reset,
	input  logic dispatch,
	input  stationIdT dispatchStation,
	input  opcodeT dispatchOp,
	input  wordT jValue,
	input  operandTagT jTag,
	input  wordT kValue,
	input  operandTagT kTag,
	input  wordT imm,
	input  robTagT tailTag,
	input  wordT [`RB_SIZE-1:0] entryValue,
	input  logic [`RB_SIZE-1:0] entryDone,
	output logic busy,
	output logic resultValid,
	output robTagT resultTag,
	output wordT resultValue
);

	localparam int COUNT_WIDTH = $clog2(`MUL_STALL + 1);

	opcodeT op;
	wordT vj;
	wordT vk;
	operandTagT qj;
	operandTagT qk;
	robTagT dest;
	logic [COUNT_WIDTH-1:0] mulCount;

	logic take;
	logic isMul;
	logic isSub;
	logic jReady;
	logic kReady;
	wordT jNow;
	wordT kNow;
	logic fire;
	logic mulDone;

	// operand is ready if held already or its entry has finished
	function automatic logic tagReady(operandTagT t);
		return !t.pending || entryDone[t.tag];
	endfunction

	function automatic wordT tagValue(operandTagT t, wordT v);
		return t.pending ? entryValue[t.tag] : v;
	endfunction

	assign take = dispatch && dispatchStation == stationIdT'(stationIndex);
	assign isMul = op == MUL || op == MULI;
	assign isSub = op == SUB || op == SUBI;

	// operand view for this cycle, polled from the reorder buffer
	assign jReady = tagReady(qj);
	assign kReady = tagReady(qk);
	assign jNow = tagValue(qj, vj);
	assign kNow = tagValue(qk, vk);

	// start execution once, and not while the multiplier counts or a result is out
	assign fire = busy && !resultValid && mulCount == '0 && jReady && kReady;
	assign mulDone = mulCount == COUNT_WIDTH'(1);

	assign resultTag = dest;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy <= 1'b0;
			resultValid <= 1'b0;
			mulCount <= '0;
		end else begin
			// one cycle result beat, the reorder buffer takes it at the next edge
			resultValid <= (fire && !isMul) || mulDone;
			if (take) begin
				busy <= 1'b1;
			end else if (resultValid) begin
				busy <= 1'b0;
			end
			if (fire && isMul) begin
				mulCount <= COUNT_WIDTH'(`MUL_STALL);
			end else if (mulCount != '0) begin
				mulCount <= mulCount - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			op <= dispatchOp;
			dest <= tailTag;
			// an operand whose entry is already done is grabbed right away
			vj <= tagValue(jTag, jValue);
			qj <= tagReady(jTag) ? TAG_READY : jTag;
			if (dispatchOp == ADDI || dispatchOp == SUBI || dispatchOp == MULI) begin
				vk <= imm;
				qk <= TAG_READY;
			end else begin
				vk <= tagValue(kTag, kValue);
				qk <= tagReady(kTag) ? TAG_READY : kTag;
			end
		end else if (busy) begin
			// keep watching the entries for the missing operands
			if (jReady) begin
				vj <= jNow;
				qj <= TAG_READY;
			end
			if (kReady) begin
				vk <= kNow;
				qk <= TAG_READY;
			end
		end
		// results wrap to the word size
		if (fire && !isMul) begin
			resultValue <= isSub ? jNow - kNow : jNow + kNow;
		end else if (mulDone) begin
			resultValue <= vj * vk;
		end
	end

endmodule

// ==== rtl/reorderBuffer.sv ====
`timescale 1ns/1ps
`include "aluCore_config.svh"

module reorderBuffer
	import isaPkg::*;
	import robPkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic allocate,
	input  regIdxT allocReg,
	input  logic [`FU_NUM-1:0] resultValid,
	input  robTagT [`FU_NUM-1:0] resultTag,
	input  wordT [`FU_NUM-1:0] resultValue,
	output robTagT tailTag,
	output logic robFull,
	output wordT [`RB_SIZE-1:0] entryValue,
	output logic [`RB_SIZE-1:0] entryDone,
	output logic commitValid,
	output regIdxT commitReg,
	output robTagT commitTag,
	output wordT commitValue
);

	localparam int COUNT_WIDTH = $clog2(`RB_SIZE + 1);

	robTagT head;
	robTagT tail;
	logic [COUNT_WIDTH-1:0] count;
	regIdxT destReg [`RB_SIZE];

	// wraps even when the depth is not a power of two
	function automatic robTagT nextTag(robTagT t);
		return (t == robTagT'(`RB_SIZE - 1)) ? '0 : t + 1'b1;
	endfunction

	assign tailTag = tail;
	assign robFull = count == COUNT_WIDTH'(`RB_SIZE);

	// head retires as soon as its result is in
	assign commitValid = entryDone[head];
	assign commitTag = head;
	assign commitReg = destReg[head];
	assign commitValue = entryValue[head];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			entryDone <= '0;
		end else begin
			if (allocate) begin
				entryDone[tail] <= 1'b0;
				tail <= nextTag(tail);
			end
			// every station has its own slot, so all of them land together
			for (int i = 0; i < `FU_NUM; i++) begin
				if (resultValid[i]) begin
					entryDone[resultTag[i]] <= 1'b1;
				end
			end
			if (commitValid) begin
				entryDone[head] <= 1'b0;
				head <= nextTag(head);
			end
			case ({allocate, commitValid})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// destination register and value per entry
	always_ff @(posedge clk) begin
		if (allocate) begin
			destReg[tail] <= allocReg;
		end
		for (int i = 0; i < `FU_NUM; i++) begin
			if (resultValid[i]) begin
				entryValue[resultTag[i]] <= resultValue[i];
			end
		end
	end

endmodule

// ==== rtl/aluCore.sv ====
`timescale 1ns/1ps
`include "aluCore_config.svh"

module aluCore
	import isaPkg::*;
	import robPkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic instValid,
	input  instT inst,
	output logic stall,
	output logic commitValid,
	output regIdxT commitReg,
	output wordT commitValue
);

	// issue to stations and rename
	logic dispatch;
	stationIdT dispatchStation;
	opcodeT dispatchOp;
	regIdxT rsIdx;
	regIdxT rtIdx;
	wordT imm;
	logic allocate;
	regIdxT allocReg;
	logic [`FU_NUM-1:0] stationBusy;

	// reorder buffer side
	logic robFull;
	robTagT tailTag;
	robTagT commitTag;
	wordT [`RB_SIZE-1:0] entryValue;
	logic [`RB_SIZE-1:0] entryDone;

	// operands out of the register file
	wordT rsValue;
	wordT rtValue;
	operandTagT rsTag;
	operandTagT rtTag;

	// one result slot per station
	logic [`FU_NUM-1:0] resultValid;
	robTagT [`FU_NUM-1:0] resultTag;
	wordT [`FU_NUM-1:0] resultValue;

	issueUnit issue (
		.instValid(instValid), .inst(inst), .stationBusy(stationBusy), .robFull(robFull),
		.stall(stall), .dispatch(dispatch), .dispatchStation(dispatchStation),
		.dispatchOp(dispatchOp), .rsIdx(rsIdx), .rtIdx(rtIdx), .imm(imm),
		.allocate(allocate), .allocReg(allocReg)
	);

	registerFile regs (
		.clk(clk), .reset(reset), .rsIdx(rsIdx), .rtIdx(rtIdx),
		.allocate(allocate), .allocReg(allocReg), .tailTag(tailTag),
		.commitValid(commitValid), .commitReg(commitReg), .commitTag(commitTag),
		.commitValue(commitValue), .rsValue(rsValue), .rsTag(rsTag),
		.rtValue(rtValue), .rtTag(rtTag)
	);

	// rs feeds the j operand, rt the k operand
	for (genvar i = 0; i < `FU_NUM; i++) begin : gStation
		aluStation #(.stationIndex(i)) station (
			.clk(clk), .reset(reset), .dispatch(dispatch), .dispatchStation(dispatchStation),
			.dispatchOp(dispatchOp), .jValue(rsValue), .jTag(rsTag),
			.kValue(rtValue), .kTag(rtTag), .imm(imm), .tailTag(tailTag),
			.entryValue(entryValue), .entryDone(entryDone), .busy(stationBusy[i]),
			.resultValid(resultValid[i]), .resultTag(resultTag[i]),
			.resultValue(resultValue[i])
		);
	end

	reorderBuffer rob (
		.clk(clk), .reset(reset), .allocate(allocate), .allocReg(allocReg),
		.resultValid(resultValid), .resultTag(resultTag), .resultValue(resultValue),
		.tailTag(tailTag), .robFull(robFull), .entryValue(entryValue),
		.entryDone(entryDone), .commitValid(commitValid), .commitReg(commitReg),
		.commitTag(commitTag), .commitValue(commitValue)
	);

endmodule

// ==== bench/aluCore_asserts.sv ====
`timescale 1ns/1ps
`include "aluCore_config.svh"

module robAsserts #(
	parameter int COUNT_WIDTH = $clog2(`RB_SIZE + 1)
) (
	input logic clk,
	input logic reset,
	input logic allocate,
	input logic robFull,
	input logic commitValid,
	input logic [COUNT_WIDTH-1:0] count
);

	// failed properties counted for the testbench
	int failCount = 0;

	// a done head is always an allocated entry, so an empty buffer never commits
	commitNeedsEntry: assert property (@(posedge clk) disable iff (reset)
		commitValid |-> count != '0)
	else begin
		failCount++;
		$error("commit raised while the reorder buffer is empty");
	end

	// occupancy stays within the buffer depth
	countBounded: assert property (@(posedge clk) disable iff (reset)
		count <= COUNT_WIDTH'(`RB_SIZE))
	else begin
		failCount++;
		$error("reorder buffer count went past its depth");
	end

	// issue must hold back while every entry is taken
	noAllocWhenFull: assert property (@(posedge clk) disable iff (reset)
		robFull |-> !allocate)
	else begin
		failCount++;
		$error("allocate raised while the reorder buffer is full");
	end

endmodule

bind reorderBuffer robAsserts i_robAsserts (
	.clk(clk), .reset(reset), .allocate(allocate), .robFull(robFull),
	.commitValid(commitValid), .count(count)
);

// ==== bench/aluCoreTb.sv ====
`timescale 1ns/1ps
`include "aluCore_config.svh"

module aluCoreTb
	import isaPkg::*;
;

	// a table row holds the instruction and the commit it should produce
	typedef struct {
		instT inst;
		bit burst;
		bit commits;
		regIdxT expReg;
		wordT expValue;
	} rowT;

	logic clk = 1'b0;
	logic reset;
	logic instValid;
	instT inst;
	logic stall;
	logic commitValid;
	regIdxT commitReg;
	wordT commitValue;

	rowT rows[$];
	// row indices still waiting for their commit in program order
	int expectQ[$];
	int commitCount = 0;
	int totalCommits;
	bit sawStall = 1'b0;

	aluCore i_dut (
		.clk(clk), .reset(reset), .instValid(instValid), .inst(inst),
		.stall(stall), .commitValid(commitValid), .commitReg(commitReg),
		.commitValue(commitValue)
	);

	always #5 clk = ~clk;

	task automatic check(string name, int actual, int expected);
		if (actual != expected) begin
			$display("Mismatch at %0t: %s got %0h, expected %0h",
				$time, name, actual, expected);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	// register form with rt in bits 5..3
	function automatic instT regInst(logic [3:0] opc, int rd, int rs, int rt);
		logic [15:0] bits;
		bits = {opc, 3'(rd), 3'(rs), 3'(rt), 3'b000};
		return instT'(bits);
	endfunction

	// immediate form with six bits in 5..0
	function automatic instT immInst(logic [3:0] opc, int rd, int rs, int imm);
		logic [15:0] bits;
		bits = {opc, 3'(rd), 3'(rs), 6'(imm)};
		return instT'(bits);
	endfunction

	task automatic addRow(instT i, bit burst);
		rowT row;
		row.inst = i;
		row.burst = burst;
		row.commits = 1'b0;
		row.expReg = '0;
		row.expValue = '0;
		rows.push_back(row);
	endtask

	task automatic loadTable();
		// immediates on reset values
		addRow(immInst(ADDI, 1, 2, 5), 1'b0);
		addRow(immInst(SUBI, 2, 3, 10), 1'b0);
		addRow(immInst(MULI, 3, 4, 63), 1'b0);
		// read after write chain
		addRow(regInst(ADD, 4, 1, 3), 1'b0);
		addRow(regInst(SUB, 5, 4, 1), 1'b0);
		addRow(regInst(ADD, 6, 5, 4), 1'b0);
		addRow(regInst(SUB, 7, 6, 2), 1'b0);
		// slow multiply with quick adds right behind it
		addRow(regInst(MUL, 1, 6, 7), 1'b0);
		addRow(regInst(ADD, 2, 0, 3), 1'b1);
		addRow(immInst(ADDI, 3, 0, 9), 1'b1);
		addRow(regInst(ADD, 4, 3, 3), 1'b1);
		// r5 written twice and then read
		addRow(immInst(ADDI, 5, 0, 20), 1'b0);
		addRow(immInst(SUBI, 5, 3, 1), 1'b1);
		addRow(regInst(ADD, 6, 5, 5), 1'b1);
		addRow(immInst(ADDI, 7, 5, 0), 1'b0);
		// undefined opcodes then a normal one
		addRow(immInst(4'hE, 0, 1, 1), 1'b0);
		addRow(immInst(4'hF, 2, 2, 2), 1'b1);
		addRow(immInst(ADDI, 0, 7, 2), 1'b1);
		// dependent multiplies hold the head while a back to back burst piles up
		addRow(regInst(MUL, 1, 1, 1), 1'b0);
		addRow(regInst(MUL, 2, 1, 2), 1'b1);
		for (int k = 0; k < 10; k++) begin
			addRow(immInst(ADDI, 3 + k % 5, 0, k + 1), 1'b1);
		end
		addRow(regInst(SUB, 3, 2, 1), 1'b1);
		addRow(regInst(ADD, 0, 3, 7), 1'b0);
	endtask

	// in order reference model where register i starts at i
	task automatic buildExpected();
		wordT regs [`REG_NUM];
		logic [15:0] bits;
		logic [3:0] opc;
		wordT a;
		wordT b;
		wordT res;
		for (int r = 0; r < `REG_NUM; r++) begin
			regs[r] = wordT'(r);
		end
		for (int i = 0; i < rows.size(); i++) begin
			bits = rows[i].inst;
			opc = bits[15:12];
			a = regs[bits[8:6]];
			res = '0;
			// immediate forms zero extend the low six bits
			if (opc == ADDI || opc == SUBI || opc == MULI) begin
				b = wordT'(bits[5:0]);
			end else begin
				b = regs[bits[5:3]];
			end
			rows[i].commits = 1'b1;
			case (opc)
				ADD, ADDI: res = a + b;
				SUB, SUBI: res = a - b;
				MUL, MULI: res = a * b;
				default: rows[i].commits = 1'b0;
			endcase
			if (rows[i].commits) begin
				regs[bits[11:9]] = res;
				rows[i].expReg = bits[11:9];
				rows[i].expValue = res;
				expectQ.push_back(i);
			end
		end
	endtask

	// commit monitor sampled mid cycle
	always @(negedge clk) begin : commitMonitor
		int r;
		if (!reset && commitValid) begin
			if (expectQ.size() == 0) begin
				$display("Unexpected commit at %0t: r%0d = %0h arrived with nothing left to commit",
					$time, commitReg, commitValue);
				$display("sim failed");
				$fatal(1);
			end else begin
				r = expectQ.pop_front();
				check("commitReg", int'(commitReg), int'(rows[r].expReg));
				check("commitValue", int'(commitValue), int'(rows[r].expValue));
				commitCount++;
			end
		end
	end

	// an assertion failure in the reorder buffer ends the run right away
	always @(i_dut.rob.i_robAsserts.failCount) begin
		if (i_dut.rob.i_robAsserts.failCount != 0) begin
			$display("Reorder buffer assertion failed at %0t", $time);
			$display("sim failed");
			$fatal(1);
		end
	end

	initial begin
		int unsigned gap;
		bit accepted;
		reset = 1'b1;
		instValid = 1'b0;
		inst = '0;
		void'($urandom(59));
		loadTable();
		buildExpected();
		totalCommits = expectQ.size();

		// watchdog sized from the table length
		fork
			begin
				#(rows.size() * (`MUL_STALL + `RB_SIZE + 4) * 10);
				$display("Timeout at %0t: commits stopped arriving, %0d of %0d seen",
					$time, commitCount, totalCommits);
				$display("sim failed");
				$fatal(1);
			end
		join_none

		repeat (2) @(posedge clk);
		#1 reset = 1'b0;

		for (int i = 0; i < rows.size(); i++) begin
			if (!rows[i].burst) begin
				gap = $urandom % 4;
				instValid = 1'b0;
				repeat (gap) begin
					@(posedge clk);
					#1;
				end
			end
			instValid = 1'b1;
			inst = rows[i].inst;
			accepted = 1'b0;
			// hold the instruction until an edge with stall low
			while (!accepted) begin
				@(negedge clk);
				accepted = !stall;
				if (stall && rows[i].burst) begin
					sawStall = 1'b1;
				end
				@(posedge clk);
				#1;
			end
		end
		instValid = 1'b0;

		while (expectQ.size() != 0) begin
			@(posedge clk);
		end
		// a few idle cycles catch any stray commit
		repeat (4) @(posedge clk);
		check("stall", int'(sawStall), 1);

		if (i_dut.rob.i_robAsserts.failCount == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			$display("Reorder buffer assertions failed %0d times",
				i_dut.rob.i_robAsserts.failCount);
			$display("sim failed");
			$fatal(1);
		end
	end

endmodule

// ==== build.f ====
+incdir+rtl
rtl/isaPkg.sv
rtl/robPkg.sv
rtl/issueUnit.sv
rtl/registerFile.sv
rtl/aluStation.sv
rtl/reorderBuffer.sv
rtl/aluCore.sv
bench/aluCore_asserts.sv
bench/aluCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# build from the file list, run, and pass only when the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module aluCoreTb -f build.f &&
./obj_dir/ValuCoreTb | tee /dev/stderr | grep -qx "sim passed" ||
{ echo "simulation did not pass"; exit 1; }
